// File: tests/core_stim.txt
# i <byte address hex> <instruction hex> | t <test name> | w <rd decimal> <data hex> | h
# expected writes are listed in program order
t itype
i 00 ffb00093
i 04 ffc0a113
i 08 0050b193
i 0c 0f00c213
i 10 12016293
i 14 03c27313
i 18 02829393
i 1c 03c0d413
i 20 4010d493
i 24 42425513
w 1 fffffffffffffffb
w 2 0000000000000001
w 3 0000000000000000
w 4 ffffffffffffff0b
w 5 0000000000000121
w 6 0000000000000008
w 7 0001210000000000
w 8 000000000000000f
w 9 fffffffffffffffd
w 10 ffffffffffffffff
t rtype
i 28 006285b3
i 2c 40530633
i 30 00c296b3
i 34 00262733
i 38 002637b3
i 3c 0062c833
i 40 0080d8b3
i 44 4080d933
i 48 0083e9b3
i 4c 00567a33
w 11 0000000000000129
w 12 fffffffffffffee7
w 13 0000908000000000
w 14 0000000000000001
w 15 0000000000000000
w 16 0000000000000129
w 17 0001ffffffffffff
w 18 ffffffffffffffff
w 19 000121000000000f
w 20 0000000000000021
t branch
i 50 00610663
i 54 00210663
i 60 001a8a93
i 64 00211663
i 68 00611663
i 74 001a8a93
i 78 00134663
i 7c 0060c663
i 88 001a8a93
i 8c 0060d663
i 90 00135663
i 9c 001a8a93
i a0 0060e663
i a4 00136663
i b0 001a8a93
i b4 00137663
i b8 0060f663
i c4 001a8a93
w 21 0000000000000001
w 21 0000000000000002
w 21 0000000000000003
w 21 0000000000000004
w 21 0000000000000005
w 21 0000000000000006
t jump
i c8 00c00b6f
i d4 00001b97
i d8 80000c37
i dc 0f1b0ce7
i 1bc 05500d13
w 22 00000000000000cc
w 23 00000000000010d4
w 24 ffffffff80000000
w 25 00000000000000e0
w 26 0000000000000055
t halt
i 1c0 00100073
i 1c4 00100d93
h

// File: sources.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/pipe_reg.sv
rtl/ctrl.sv
rtl/id.sv
rtl/regs.sv
rtl/ex.sv
rtl/core_top.sv
tests/tb_clk.sv
tests/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(filter-out +incdir+%,$(shell cat sources.f))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sources.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_top.sv
`timescale 1ns/1ps

module tb_top import isa_pkg::*; ();

    localparam logic [63:0] RESET_PC  = 64'h0;
    localparam int          IMG_WORDS = 128;
    localparam int          TIMEOUT   = 200;
    localparam int          QUIET     = 20; // cycles without writes after halt

    logic        clk;
    logic        arst_n_i;
    logic [31:0] inst_i;
    logic [63:0] pc_o;
    logic        rd_wen_o;
    logic [4:0]  rd_waddr_o;
    logic [63:0] rd_wdata_o;
    logic        halt_o;

    logic [31:0] img [IMG_WORDS];
    int          ev_kind [$]; // 0 test start, 1 write, 2 halt
    string       ev_name [$];
    logic [4:0]  ev_rd [$];
    logic [63:0] ev_data [$];

    string cur_name;
    int    test_errs;
    int    n_pass;
    int    n_fail;
    bit    load_ok;

    tb_clk u_clk (
        .clk_o(clk)
    );

    core_top #(
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .inst_i    (inst_i),
        .pc_o      (pc_o),
        .rd_wen_o  (rd_wen_o),
        .rd_waddr_o(rd_waddr_o),
        .rd_wdata_o(rd_wdata_o),
        .halt_o    (halt_o)
    );

    // instruction memory answers in the same cycle
    always @(negedge clk) begin
        if (pc_o < 64'(IMG_WORDS * 4)) begin
            inst_i = img[pc_o[8:2]];
        end else begin
            inst_i = INST_NOP;
        end
    end

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        string       tag;
        string       name;
        logic [63:0] a;
        logic [63:0] d;
        fd = $fopen("tests/core_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/core_stim.txt");
            return;
        end
        load_ok = 1'b1;
        while (!$feof(fd)) begin
            line = "";
            tag  = "";
            n    = $fgets(line, fd);
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s", tag);
            if (tag == "i") begin
                n = $sscanf(line, "%s %h %h", tag, a, d);
                img[a[8:2]] = d[31:0];
            end else if (tag == "t" || tag == "w" || tag == "h") begin
                name = "";
                a    = '0;
                d    = '0;
                if (tag == "t") begin
                    n = $sscanf(line, "%s %s", tag, name);
                end else if (tag == "w") begin
                    n = $sscanf(line, "%s %d %h", tag, a, d);
                end
                ev_kind.push_back(tag == "t" ? 0 : (tag == "w" ? 1 : 2));
                ev_name.push_back(name);
                ev_rd.push_back(a[4:0]);
                ev_data.push_back(d);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_reset_state();
        if (rd_wen_o !== 1'b0) begin
            $display("Mismatch rd_wen_o: expected %h, got %h", 1'b0, rd_wen_o);
            test_errs++;
        end
        if (halt_o !== 1'b0) begin
            $display("Mismatch halt_o: expected %h, got %h", 1'b0, halt_o);
            test_errs++;
        end
        if (pc_o !== RESET_PC) begin
            $display("Mismatch pc_o: expected %h, got %h", RESET_PC, pc_o);
            test_errs++;
        end
    endtask

    task automatic expect_write(input logic [4:0] rd, input logic [63:0] data);
        bit seen;
        seen = 1'b0;
        for (int cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
            @(negedge clk);
            seen = rd_wen_o;
        end
        if (!seen) begin
            $display("%s: timed out waiting for write to x%0d", cur_name, rd);
            test_errs++;
            return;
        end
        if (rd_waddr_o !== rd) begin
            $display("Mismatch rd_waddr_o: expected %h, got %h", rd, rd_waddr_o);
            test_errs++;
        end
        if (rd_wdata_o !== data) begin
            $display("Mismatch rd_wdata_o: expected %h, got %h", data, rd_wdata_o);
            test_errs++;
        end
    endtask

    task automatic expect_halt();
        bit seen;
        seen = 1'b0;
        for (int cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
            @(negedge clk);
            if (rd_wen_o) begin
                $display("%s: unexpected write to x%0d before halt", cur_name, rd_waddr_o);
                test_errs++;
            end
            seen = halt_o;
        end
        if (!seen) begin
            $display("%s: timed out waiting for halt", cur_name);
            test_errs++;
            return;
        end
        for (int cyc = 0; cyc < QUIET; cyc++) begin
            @(negedge clk);
            if (rd_wen_o) begin
                $display("%s: write enable rose after halt", cur_name);
                test_errs++;
            end
            if (!halt_o) begin
                $display("%s: halt_o dropped before reset", cur_name);
                test_errs++;
            end
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            n_pass++;
            $display("test %s: ok", cur_name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", cur_name, test_errs);
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        inst_i   = INST_NOP;
        n_pass   = 0;
        n_fail   = 0;
        load_ok  = 1'b0;
        for (int i = 0; i < IMG_WORDS; i++) begin
            img[i] = (32'(i) << 20) | 32'h0000_0f93; // addi x31, x0, index
        end
        load_stim();

        cur_name  = "reset";
        test_errs = 0;
        repeat (10) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_state();
        end
        arst_n_i = 1'b1;
        #1;
        check_reset_state();
        finish_test();

        for (int k = 0; k < ev_kind.size(); k++) begin
            if (ev_kind[k] == 0) begin
                if (k > 0) begin
                    finish_test();
                end
                cur_name  = ev_name[k];
                test_errs = 0;
            end else if (ev_kind[k] == 1) begin
                expect_write(ev_rd[k], ev_data[k]);
            end else begin
                expect_halt();
            end
        end
        if (ev_kind.size() > 0) begin
            finish_test();
        end
        if (!load_ok || ev_kind.size() == 0) begin
            $display("no stimulus was loaded");
            n_fail++;
        end

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/tb_clk.sv
`timescale 1ns/1ps

module tb_clk #(
    parameter int HALF_PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o; // 40 ns period
    end

endmodule

// File: rtl/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic [31:0]     inst_i,
    output logic [XLEN-1:0] pc_o,
    output logic            rd_wen_o,
    output logic [4:0]      rd_waddr_o,
    output logic [XLEN-1:0] rd_wdata_o,
    output logic            halt_o
);

    logic            fetch_valid;
    logic            flush;
    logic            hold;
    logic            ebreak;
    jump_t           jump;
    wb_t             wb;
    if_id_t          if_id_d;
    if_id_t          if_id_q;
    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    ctrl #(
        .RESET_PC(RESET_PC)
    ) u_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .jump_i       (jump),
        .ebreak_i     (ebreak),
        .pc_o         (pc_o),
        .fetch_valid_o(fetch_valid),
        .flush_o      (flush),
        .hold_o       (hold),
        .halt_o       (halt_o)
    );

    assign if_id_d = '{valid: fetch_valid, pc: pc_o, inst: inst_i}; // same-cycle fetch

    pipe_reg #(.T(if_id_t)) u_if_id (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .flush_i (flush),
        .hold_i  (hold),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    id u_id (
        .if_id_i   (if_id_q),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .id_ex_o   (id_ex_d)
    );

    regs u_regs (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .wb_i      (wb),
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

    pipe_reg #(.T(id_ex_t)) u_id_ex (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .flush_i (flush),
        .hold_i  (hold),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    ex u_ex (
        .id_ex_i (id_ex_q),
        .wb_o    (wb),
        .jump_o  (jump),
        .ebreak_o(ebreak)
    );

    assign rd_wen_o   = wb.wen;
    assign rd_waddr_o = wb.waddr;
    assign rd_wdata_o = wb.wdata;

endmodule

// File: rtl/ex.sv
`timescale 1ns/1ps

module ex import isa_pkg::*, core_pkg::*; (
    input  id_ex_t id_ex_i,
    output wb_t    wb_o,
    output jump_t  jump_o,
    output logic   ebreak_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [5:0]      shamt;

    logic [XLEN-1:0] add_res;
    logic [XLEN-1:0] sub_res;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] target_sum;
    logic [XLEN-1:0] alu_res;
    logic            br_take;

    assign opcode = opcode_e'(id_ex_i.inst[6:0]);
    assign funct3 = id_ex_i.inst[14:12];
    assign funct7 = id_ex_i.inst[31:25];
    assign op1    = id_ex_i.op1;
    assign op2    = id_ex_i.op2;
    assign shamt  = op2[5:0];

    assign add_res    = op1 + op2;
    assign sub_res    = op1 - op2;
    assign sll_res    = op1 << shamt;
    assign srl_res    = op1 >> shamt;
    assign sra_res    = $signed(op1) >>> shamt; // full 64-bit sign fill
    assign eq         = (op1 == op2);
    assign lt_s       = ($signed(op1) < $signed(op2));
    assign lt_u       = (op1 < op2);
    assign target_sum = id_ex_i.base_addr + id_ex_i.offset_addr;

    always_comb begin
        case (funct3)
            F3_ADD_SUB: alu_res = (opcode == OP && funct7[F7_ALT_BIT]) ? sub_res : add_res;
            F3_SLL:     alu_res = sll_res;
            F3_SLT:     alu_res = {{(XLEN-1){1'b0}}, lt_s};
            F3_SLTU:    alu_res = {{(XLEN-1){1'b0}}, lt_u};
            F3_XOR:     alu_res = op1 ^ op2;
            F3_SR:      alu_res = funct7[F7_ALT_BIT] ? sra_res : srl_res;
            F3_OR:      alu_res = op1 | op2;
            default:    alu_res = op1 & op2; // F3_AND
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  br_take = eq;
            F3_BNE:  br_take = ~eq;
            F3_BLT:  br_take = lt_s;
            F3_BGE:  br_take = ~lt_s;
            F3_BLTU: br_take = lt_u;
            F3_BGEU: br_take = ~lt_u;
            default: br_take = 1'b0;
        endcase
    end

    always_comb begin
        wb_o        = '0;
        jump_o      = '0;
        wb_o.waddr  = id_ex_i.rd_addr;
        jump_o.addr = {target_sum[XLEN-1:1], 1'b0}; // jalr lsb clear, others already even
        if (id_ex_i.valid) begin
            case (opcode)
                OP_IMM, OP: begin
                    wb_o.wen   = id_ex_i.reg_wen;
                    wb_o.wdata = alu_res;
                end
                BRANCH: jump_o.en = br_take;
                JAL, JALR: begin
                    wb_o.wen   = id_ex_i.reg_wen;
                    wb_o.wdata = add_res; // pc + 4
                    jump_o.en  = 1'b1;
                end
                LUI: begin
                    wb_o.wen   = id_ex_i.reg_wen;
                    wb_o.wdata = op2;
                end
                AUIPC: begin
                    wb_o.wen   = id_ex_i.reg_wen;
                    wb_o.wdata = add_res;
                end
                default: begin
                end
            endcase
        end
        if (!id_ex_i.valid) begin
            wb_o.waddr  = '0;
            jump_o.addr = '0;
        end
    end

    assign ebreak_o = id_ex_i.valid && (id_ex_i.inst == INST_EBREAK);

endmodule

// File: rtl/regs.sv
`timescale 1ns/1ps

module regs import core_pkg::*; (
    input  logic            clk,
    input  logic            arst_n_i,
    input  wb_t             wb_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o
);

    logic [XLEN-1:0] rf_q [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wb_i.wen && wb_i.waddr != 5'd0) begin
            rf_q[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // same-cycle write data wins over the stored value
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 :
                        (wb_i.wen && wb_i.waddr == rs1_addr_i) ? wb_i.wdata :
                        rf_q[rs1_addr_i];

    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 :
                        (wb_i.wen && wb_i.waddr == rs2_addr_i) ? wb_i.wdata :
                        rf_q[rs2_addr_i];

endmodule

// File: rtl/id.sv
`timescale 1ns/1ps

module id import isa_pkg::*, core_pkg::*; (
    input  if_id_t          if_id_i,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output id_ex_t          id_ex_o
);

    logic [31:0]     inst;
    opcode_e         opcode;
    logic [4:0]      rd;
    logic            rd_nz;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;

    assign inst   = if_id_i.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign rd     = inst[11:7];
    assign rd_nz  = (rd != 5'd0);

    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    // immediates, all sign extended
    assign imm_i = {{52{inst[31]}}, inst[31:20]}; // shamt sits in [5:0]
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};

    always_comb begin
        id_ex_o         = '0;
        id_ex_o.valid   = if_id_i.valid;
        id_ex_o.inst    = inst;
        id_ex_o.rd_addr = rd;
        case (opcode)
            OP_IMM: begin
                id_ex_o.op1     = rs1_data_i;
                id_ex_o.op2     = imm_i;
                id_ex_o.reg_wen = rd_nz;
            end
            OP: begin
                id_ex_o.op1     = rs1_data_i;
                id_ex_o.op2     = rs2_data_i;
                id_ex_o.reg_wen = rd_nz;
            end
            BRANCH: begin
                id_ex_o.op1         = rs1_data_i;
                id_ex_o.op2         = rs2_data_i;
                id_ex_o.base_addr   = if_id_i.pc;
                id_ex_o.offset_addr = imm_b;
            end
            JAL: begin
                id_ex_o.op1         = if_id_i.pc;
                id_ex_o.op2         = XLEN'(4); // link = pc + 4
                id_ex_o.base_addr   = if_id_i.pc;
                id_ex_o.offset_addr = imm_j;
                id_ex_o.reg_wen     = rd_nz;
            end
            JALR: begin
                id_ex_o.op1         = if_id_i.pc;
                id_ex_o.op2         = XLEN'(4);
                id_ex_o.base_addr   = rs1_data_i;
                id_ex_o.offset_addr = imm_i;
                id_ex_o.reg_wen     = rd_nz;
            end
            LUI: begin
                id_ex_o.op2     = imm_u; // op1 stays zero
                id_ex_o.reg_wen = rd_nz;
            end
            AUIPC: begin
                id_ex_o.op1     = if_id_i.pc;
                id_ex_o.op2     = imm_u;
                id_ex_o.reg_wen = rd_nz;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: rtl/ctrl.sv
`timescale 1ns/1ps

module ctrl import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  jump_t           jump_i,
    input  logic            ebreak_i,
    output logic [XLEN-1:0] pc_o,
    output logic            fetch_valid_o,
    output logic            flush_o,
    output logic            hold_o,
    output logic            halt_o
);

    logic [XLEN-1:0] pc_q;
    logic            halt_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q   <= RESET_PC;
            halt_q <= 1'b0;
        end else begin
            if (ebreak_i) begin
                halt_q <= 1'b1; // sticky until reset
            end
            if (!(halt_q || ebreak_i)) begin
                pc_q <= jump_i.en ? jump_i.addr : pc_q + XLEN'(4);
            end
        end
    end

    assign pc_o          = pc_q;
    assign fetch_valid_o = ~halt_q;
    assign flush_o       = jump_i.en | ebreak_i | halt_q; // kill the two younger stages
    assign hold_o        = halt_q;
    assign halt_o        = halt_q;

endmodule

// File: rtl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n_i,
    input  logic flush_i,
    input  logic hold_i,
    input  T     d_i,
    output T     q_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0; // valid bit drops with the rest
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

    localparam int unsigned XLEN = 64;

    // fetch to decode
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic            valid;
        logic [31:0]     inst;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic [XLEN-1:0] base_addr;
        logic [XLEN-1:0] offset_addr;
        logic [4:0]      rd_addr;
        logic            reg_wen;
    } id_ex_t;

    // execute to register file
    typedef struct packed {
        logic            wen;
        logic [4:0]      waddr;
        logic [XLEN-1:0] wdata;
    } wb_t;

    // execute to control
    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] addr;
    } jump_t;

endpackage

// File: rtl/isa_pkg.sv
package isa_pkg;

    // major opcodes of the supported RV64I subset
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // alu funct3, shared by OP_IMM and OP
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl and sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam int unsigned F7_ALT_BIT = 5; // selects sub and sra

    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
    localparam logic [31:0] INST_NOP    = 32'h0000_0013; // addi x0, x0, 0

endpackage
